// ==== rtl/tcb_pkg.sv ====
// TCB bus transfer types
// address, data and byte enable widths, request and response structures

package tcb_pkg;

  ////////////////////
  // widths
  ////////////////////

  localparam int unsigned TCB_ADR_W = 16;  // byte address width
  localparam int unsigned TCB_DAT_W = 32;  // data word width

  // bytes per data word, drives byte enable loops
  localparam int unsigned TCB_DAT_BYTES = TCB_DAT_W / 8;

  ////////////////////
  // basic types
  ////////////////////

  typedef logic [TCB_ADR_W-1:0]     tcb_adr_t;  // byte address
  typedef logic [TCB_DAT_W-1:0]     tcb_dat_t;  // data word
  typedef logic [TCB_DAT_BYTES-1:0] tcb_ben_t;  // one enable per byte

  ////////////////////
  // request/response
  ////////////////////

  // request, held stable by the manager until transfer
  typedef struct packed {
    logic     wen;  // write enable, read when low
    tcb_adr_t adr;  // byte address
    tcb_ben_t ben;  // byte enables for writes
    tcb_dat_t wdt;  // write data
  } tcb_req_t;

  // response, valid only in the cycle after transfer
  typedef struct packed {
    tcb_dat_t rdt;  // read data
  } tcb_rsp_t;

endpackage: tcb_pkg

// ==== rtl/tcb_mem_pkg.sv ====
// memory subordinate types
// byte offset, word index and expanded write mask

package tcb_mem_pkg;

  import tcb_pkg::*;

  ////////////////////
  // addressing
  ////////////////////

  // byte offset bits inside a word, dropped from the address
  localparam int unsigned MEM_OFF = $clog2(TCB_DAT_BYTES);

  // word index, address minus byte offset
  // only the low MEM_AW bits reach the array, the rest alias
  typedef logic [$bits(tcb_adr_t)-MEM_OFF-1:0] mem_idx_t;

  ////////////////////
  // write masking
  ////////////////////

  // bit mask expanded from the byte enables
  // one byte of ones per enabled byte lane
  typedef logic [$bits(tcb_dat_t)-1:0] mem_wmask_t;

endpackage: tcb_mem_pkg

// ==== rtl/tcb_if.sv ====
// TCB interface
// valid/ready handshake, request and response, manager and subordinate modports

`timescale 1ns/100ps

interface tcb_if
  import tcb_pkg::*;
(
  input logic man,    // clock
  input logic rst_n   // async reset, active low
);

  ////////////////////
  // bus signals
  ////////////////////

  logic     vld;  // request valid, from manager
  logic     rdy;  // ready, from subordinate
  tcb_req_t req;  // request payload
  tcb_rsp_t rsp;  // response, one cycle after trn

  logic     trn;  // transfer

  // transfer when both sides agree on this edge
  assign trn = vld & rdy;

  ////////////////////
  // modports
  ////////////////////

  // manager side drives the request
  modport mgr (
    input  man, rst_n,
    output vld, req,
    input  rdy, rsp, trn
  );

  // subordinate side answers it
  modport sub (
    input  man, rst_n,
    input  vld, req,
    output rdy, rsp,
    input  trn
  );

endinterface: tcb_if

// ==== rtl/tcb_lib_arbiter.sv ====
// round-robin arbiter
// rotating priority pointer, combinational select from request valids

`timescale 1ns/100ps

module tcb_lib_arbiter #(
  parameter  int unsigned SPN = 2,           // number of manager ports
  localparam int unsigned SPL = $clog2(SPN)  // select width
)(
  input  logic           man,     // clock
  input  logic           rst_n,   // async reset, active low
  input  logic [SPN-1:0] vld,     // request valid per port
  input  logic           trn,     // transfer on the shared bus
  output logic [SPL-1:0] sel      // granted port
);

  ////////////////////
  // local signals
  ////////////////////

  logic [SPL-1:0] ptr;    // highest priority port
  logic [SPL-1:0] nxt;    // port after the granted one
  logic           found;  // a requesting port was seen
  int unsigned    idx;    // port under test while scanning

  ////////////////////
  // select
  ////////////////////

  // scan from ptr upwards, wrapping at SPN
  always_comb begin
    sel   = ptr;  // idle, keep pointer's port
    found = 1'b0;
    idx   = 0;
    for (int unsigned i = 0; i < SPN; i++) begin
      idx = (int'(ptr) + i) % SPN;
      if (!found && vld[idx]) begin
        sel   = idx[SPL-1:0];
        found = 1'b1;
      end
    end
  end

  ////////////////////
  // priority pointer
  ////////////////////

  // wrap explicitly, SPN need not be a power of two
  assign nxt = (sel == SPL'(SPN-1)) ? '0 : sel + 1'b1;

  always_ff @(posedge man, negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;  // port 0 first after reset
    end else if (trn) begin
      ptr <= nxt;  // granted port drops to lowest priority
    end
  end

endmodule: tcb_lib_arbiter

// ==== rtl/tcb_lib_multiplexer.sv ====
// TCB multiplexer
// request mux driven by the arbiter select
// response demux driven by the select registered at transfer

`timescale 1ns/100ps

module tcb_lib_multiplexer
  import tcb_pkg::*;
#(
  parameter  int unsigned SPN = 2,           // number of manager ports
  localparam int unsigned SPL = $clog2(SPN)  // select width
)(
  input  logic [SPL-1:0] sel,            // from arbiter
  tcb_if.sub             sub [SPN-1:0],  // managers connect here
  tcb_if.mgr             mgr             // memory connects here
);

  ////////////////////
  // local signals
  ////////////////////

  logic [SPL-1:0] rsp_sel;  // owner of the response in flight

  // request side as plain arrays, indexed by sel below
  logic           tmp_vld [SPN-1:0];
  tcb_req_t       tmp_req [SPN-1:0];

  ////////////////////
  // response select
  ////////////////////

  // remember who transferred, the response follows one cycle later
  always_ff @(posedge mgr.man, negedge mgr.rst_n) begin
    if (!mgr.rst_n) begin
      rsp_sel <= '0;
    end else if (mgr.trn) begin
      rsp_sel <= sel;
    end
  end

  ////////////////////
  // request
  ////////////////////

  for (genvar i = 0; i < SPN; i++) begin: gen_req
    assign tmp_vld[i] = sub[i].vld;
    assign tmp_req[i] = sub[i].req;
  end: gen_req

  assign mgr.vld = tmp_vld[sel];  // only the granted port reaches the memory
  assign mgr.req = tmp_req[sel];

  ////////////////////
  // response
  ////////////////////

  for (genvar i = 0; i < SPN; i++) begin: gen_rsp
    // ready only for the granted port while it asks, others wait
    assign sub[i].rdy = (sel == SPL'(i)) ? (mgr.rdy & sub[i].vld) : 1'b0;
    // zero for ports not owning the response, no stale data shows
    assign sub[i].rsp = (rsp_sel == SPL'(i)) ? mgr.rsp : '0;
  end: gen_rsp

endmodule: tcb_lib_multiplexer

// ==== rtl/tcb_mem_sub.sv ====
// memory subordinate
// word array with byte enabled writes, read data registered on transfer

`timescale 1ns/100ps

module tcb_mem_sub
  import tcb_pkg::*;
  import tcb_mem_pkg::*;
#(
  parameter int unsigned MEM_AW = 8  // log2 of depth in words
)(
  tcb_if.sub bus  // from the multiplexer
);

  ////////////////////
  // local signals
  ////////////////////

  tcb_dat_t    mem [0:2**MEM_AW-1];  // storage, undefined after reset
  mem_idx_t    widx;                 // full word index from address
  logic [MEM_AW-1:0] adr;            // word actually addressed
  mem_wmask_t  wmask;                // bit mask from byte enables
  tcb_dat_t    rdt;                  // read data register

  ////////////////////
  // addressing
  ////////////////////

  assign widx = bus.req.adr[$bits(tcb_adr_t)-1:MEM_OFF];  // drop byte offset
  assign adr  = widx[MEM_AW-1:0];  // upper bits alias

  // expand each byte enable over its lane
  always_comb begin
    for (int unsigned b = 0; b < TCB_DAT_BYTES; b++) begin
      wmask[8*b +: 8] = {8{bus.req.ben[b]}};
    end
  end

  ////////////////////
  // array access
  ////////////////////

  // read before write, the response shows the old word
  always_ff @(posedge bus.man) begin
    if (bus.trn) begin
      rdt <= mem[adr];
      if (bus.req.wen) begin
        mem[adr] <= (mem[adr] & ~wmask) | (bus.req.wdt & wmask);  // merge lanes
      end
    end
  end

  ////////////////////
  // bus outputs
  ////////////////////

  assign bus.rdy = 1'b1;  // no wait states
  assign bus.rsp = '{rdt: rdt};

endmodule: tcb_mem_sub

// ==== rtl/tcb_mux_sys.sv ====
// TCB system top level
// plain manager ports wrapped into interfaces
// arbiter, multiplexer and memory subordinate

`timescale 1ns/100ps

module tcb_mux_sys
  import tcb_pkg::*;
#(
  parameter  int unsigned SPN    = 2,           // number of manager ports
  parameter  int unsigned MEM_AW = 8,           // log2 of memory depth in words
  localparam int unsigned SPL    = $clog2(SPN)  // select width
)(
  input  logic               man,              // clock
  input  logic               rst_n,            // async reset, active low
  // manager ports
  input  logic     [SPN-1:0] mgr_vld,          // request valid
  input  logic     [SPN-1:0] mgr_wen,          // write enable
  input  tcb_ben_t [SPN-1:0] mgr_ben,          // byte enables
  input  tcb_adr_t           mgr_adr [SPN-1:0],  // byte address
  input  tcb_dat_t           mgr_wdt [SPN-1:0],  // write data
  output logic     [SPN-1:0] mgr_rdy,          // grant, transfer when vld too
  output tcb_dat_t           mgr_rdt [SPN-1:0]   // read data, cycle after trn
);

  ////////////////////
  // local signals
  ////////////////////

  logic [SPN-1:0] arb_vld;  // valids gathered for the arbiter
  logic [SPL-1:0] arb_sel;  // granted port

  tcb_if tcb_mgr [SPN-1:0] (.man(man), .rst_n(rst_n));  // one per manager
  tcb_if tcb_mem           (.man(man), .rst_n(rst_n));  // mux to memory

  ////////////////////
  // port wrapping
  ////////////////////

  for (genvar i = 0; i < SPN; i++) begin: gen_port
    assign tcb_mgr[i].vld = mgr_vld[i];
    assign tcb_mgr[i].req = '{wen: mgr_wen[i], adr: mgr_adr[i],
                              ben: mgr_ben[i], wdt: mgr_wdt[i]};
    assign mgr_rdy[i] = tcb_mgr[i].rdy;
    assign mgr_rdt[i] = tcb_mgr[i].rsp.rdt;
    assign arb_vld[i] = tcb_mgr[i].vld;
  end: gen_port

  ////////////////////
  // instances
  ////////////////////

  tcb_lib_arbiter #(.SPN(SPN)) arbiter_i (
    .man   (man),
    .rst_n (rst_n),
    .vld   (arb_vld),
    .trn   (tcb_mem.trn),  // pointer moves on memory side transfer
    .sel   (arb_sel)
  );

  tcb_lib_multiplexer #(.SPN(SPN)) multiplexer_i (
    .sel (arb_sel),
    .sub (tcb_mgr),
    .mgr (tcb_mem)
  );

  tcb_mem_sub #(.MEM_AW(MEM_AW)) mem_i (
    .bus (tcb_mem)
  );

endmodule: tcb_mux_sys

// ==== verification/tcb_mux_sys_tb.sv ====
// testbench for the TCB system
// reference memory model, per-port traffic, concurrent assertions, watchdog

`timescale 1ns/100ps

module tcb_mux_sys_tb
  import tcb_pkg::*;
();

  localparam int unsigned SPN       = 3;
  localparam int unsigned MEM_AW    = 6;
  localparam int unsigned MEM_WORDS = 2**MEM_AW;
  localparam int unsigned N_DIR     = 10;  // directed byte enable sequence
  localparam int unsigned N_RAND    = 60;  // random transfers per port
  localparam int unsigned N_XFER    = MEM_WORDS + N_DIR + SPN*N_RAND;
  localparam int unsigned WD_CYCLES = N_XFER*SPN*4 + 200;

  logic               man = 1'b0;
  logic               rst_n;
  logic     [SPN-1:0] mgr_vld;
  logic     [SPN-1:0] mgr_wen;
  tcb_ben_t [SPN-1:0] mgr_ben;
  tcb_adr_t           mgr_adr [SPN-1:0];
  tcb_dat_t           mgr_wdt [SPN-1:0];
  logic     [SPN-1:0] mgr_rdy;
  tcb_dat_t           mgr_rdt [SPN-1:0];

  logic     [SPN-1:0] xfer_vec;           // transfer per port
  tcb_dat_t           model [0:MEM_WORDS-1];  // reference memory
  logic     [SPN-1:0] chk_vld;            // read result due this cycle
  tcb_dat_t           chk_exp [SPN-1:0];
  int                 wait_cnt [SPN-1:0];  // other transfers while waiting
  int                 gnt_idx, last_gnt, exp_gnt;
  logic               have_prev;          // any transfer since reset
  int                 err_data, err_grant, err_order, err_wait;
  int                 ports_done;

  tcb_mux_sys #(.SPN(SPN), .MEM_AW(MEM_AW)) tcb_mux_sys_i (.*);

  always #10 man = ~man;  // 20 ns period

  ////////////////////
  // reference model
  ////////////////////

  function automatic int word_of(tcb_adr_t adr);
    return (adr / TCB_DAT_BYTES) % MEM_WORDS;  // upper bits alias
  endfunction

  // known fill, every address bit matters
  function automatic tcb_dat_t fill(int idx);
    return tcb_dat_t'(idx * 32'h9e37_79b1) ^ 32'h3c5a_0f0f;
  endfunction

  assign xfer_vec = mgr_vld & mgr_rdy;

  always_comb begin
    gnt_idx = 0;
    for (int p = 0; p < SPN; p++) if (xfer_vec[p]) gnt_idx = p;
    exp_gnt = have_prev ? (last_gnt + 1) % SPN : 0;  // port 0 first after reset
  end

  always @(posedge man, negedge rst_n) begin
    if (!rst_n) begin
      chk_vld   <= '0;
      have_prev <= 1'b0;
      last_gnt  <= 0;
      for (int p = 0; p < SPN; p++) wait_cnt[p] <= 0;
    end else begin
      for (int p = 0; p < SPN; p++) begin
        chk_vld[p] <= xfer_vec[p] && !mgr_wen[p];  // reads only
        if (xfer_vec[p]) begin
          chk_exp[p] <= model[word_of(mgr_adr[p])];  // old word
          for (int b = 0; b < TCB_DAT_BYTES; b++) begin
            if (mgr_wen[p] && mgr_ben[p][b])
              model[word_of(mgr_adr[p])][8*b +: 8] <= mgr_wdt[p][8*b +: 8];
          end
          wait_cnt[p] <= 0;
        end else if (mgr_vld[p] && xfer_vec != '0) begin
          wait_cnt[p] <= wait_cnt[p] + 1;  // lost to another port
        end
      end
      if (xfer_vec != '0) begin
        have_prev <= 1'b1;
        last_gnt  <= gnt_idx;
      end
    end
  end

  ////////////////////
  // assertions
  ////////////////////

  for (genvar p = 0; p < SPN; p++) begin: gen_chk
    a_rdt: assert property (@(posedge man) disable iff (!rst_n)
      !chk_vld[p] || mgr_rdt[p] === chk_exp[p])
    else begin
      err_data++;
      $display("ERROR %0t mgr_rdt[%0d] expected %h actual %h", $time, p,
               $sampled(chk_exp[p]), $sampled(mgr_rdt[p]));
    end
    a_wait: assert property (@(posedge man) disable iff (!rst_n) wait_cnt[p] <= SPN-1)
    else begin
      err_wait++;
      $display("ERROR %0t wait_cnt[%0d] expected <= %0d actual %0d", $time, p,
               SPN-1, $sampled(wait_cnt[p]));
    end
  end: gen_chk

  // grants only to asking ports, one at most, one whenever anybody asks
  a_grant: assert property (@(posedge man)
    $onehot0(mgr_rdy) && (mgr_rdy & ~mgr_vld) == '0 &&
    (mgr_vld == '0 || $onehot(mgr_rdy)))
  else begin
    err_grant++;
    $display("ERROR %0t mgr_rdy expected one grant within mgr_vld %b actual %b", $time,
             $sampled(mgr_vld), $sampled(mgr_rdy));
  end

  a_order: assert property (@(posedge man) disable iff (!rst_n)
    !(&mgr_vld) || gnt_idx == exp_gnt)  // all asking, strict rotation
  else begin
    err_order++;
    $display("ERROR %0t mgr_rdy grant expected port %0d actual port %0d", $time,
             $sampled(exp_gnt), $sampled(gnt_idx));
  end

  ////////////////////
  // stimulus
  ////////////////////

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic xfer(int p, bit wen, int idx, tcb_ben_t ben, tcb_dat_t wdt);
    mgr_vld[p] = 1'b1;
    mgr_wen[p] = wen;
    mgr_ben[p] = ben;
    mgr_adr[p] = tcb_adr_t'(idx * TCB_DAT_BYTES);
    mgr_wdt[p] = wdt;
    do @(posedge man); while (!mgr_rdy[p]);  // hold until granted
    @(negedge man);
    mgr_vld[p] = 1'b0;
  endtask

  task automatic init_port(int p);
    for (int i = p; i < MEM_WORDS; i += SPN) xfer(p, 1'b1, i, '1, fill(i));
    ports_done++;
  endtask

  task automatic rand_port(int p);
    int gap;
    repeat (N_RAND) begin
      gap = $urandom_range(0, 3);
      repeat (gap) @(negedge man);
      xfer(p, 1'($urandom_range(0, 1)), $urandom_range(0, MEM_WORDS-1),
           4'($urandom_range(0, 15)), $urandom);
    end
    ports_done++;
  endtask

  task automatic run_ports(bit rnd);
    ports_done = 0;
    for (int p = 0; p < SPN; p++) begin
      automatic int q = p;
      fork
        if (rnd) rand_port(q); else init_port(q);
      join_none
    end
    wait (ports_done == SPN);
  endtask

  initial begin
    void'($urandom(73037));  // one seed for the whole run
    {err_data, err_grant, err_order, err_wait} = '0;
    rst_n   = 1'b0;
    mgr_vld = '0;
    mgr_wen = '0;
    mgr_ben = '0;
    for (int p = 0; p < SPN; p++) begin
      mgr_adr[p] = '0;
      mgr_wdt[p] = '0;
    end
    repeat (8) @(negedge man);
    rst_n = 1'b1;
    repeat (2) @(negedge man);
    run_ports(1'b0);  // fill, all ports at once
    // partial byte enables on port 0, then read back
    xfer(0, 1'b1, 5, 4'b0001, 32'h1122_3344);
    xfer(0, 1'b1, 6, 4'b0110, 32'haabb_ccdd);
    xfer(0, 1'b1, 7, 4'b1000, 32'h5566_7788);
    xfer(0, 1'b1, 8, 4'b1010, 32'h99aa_bbcc);
    xfer(0, 1'b1, 9, 4'b1111, 32'hcafe_f00d);
    for (int i = 5; i <= 9; i++) xfer(0, 1'b0, i, '0, '0);
    run_ports(1'b1);
    repeat (4) @(negedge man);  // last read check
    $display("errors: data %0d grant %0d order %0d wait %0d",
             err_data, err_grant, err_order, err_wait);
    if (err_data + err_grant + err_order + err_wait == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WD_CYCLES) @(posedge man);
    $display("timeout: run did not finish within %0d cycles", WD_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule: tcb_mux_sys_tb

// ==== tcb_mux_sys.f ====
rtl/tcb_pkg.sv
rtl/tcb_mem_pkg.sv
rtl/tcb_if.sv
rtl/tcb_lib_arbiter.sv
rtl/tcb_lib_multiplexer.sv
rtl/tcb_mem_sub.sv
rtl/tcb_mux_sys.sv
verification/tcb_mux_sys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tcb_mux_sys.f \
  --top-module tcb_mux_sys_tb -o tcb_mux_sys_sim > build.log 2>&1 &&
./obj_dir/tcb_mux_sys_sim > sim.log 2>&1 ||
{ echo "build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "^TEST RESULT: PASS$" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
